// File: Makefile
SRCS := $(wildcard hw/*.sv) $(wildcard dv/*.sv) $(wildcard include/*.svh) ddr_ctrl.f

.PHONY: all run clean

all: run

obj_dir/Vtb_ddr_ctrl: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ddr_ctrl \
		-f ddr_ctrl.f -o Vtb_ddr_ctrl

run: obj_dir/Vtb_ddr_ctrl
	./obj_dir/Vtb_ddr_ctrl | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: ddr_ctrl.f
+incdir+include
hw/ddr_ctrl_pkg.sv
hw/ddr_refresh_timer.sv
hw/ddr_cmd_sched.sv
hw/ddr_dq_path.sv
hw/ddr_ctrl_top.sv
dv/ddr_clk_gen.sv
dv/ddr_sdram_model.sv
dv/ddr_checker.sv
dv/ddr_ctrl_props.sv
dv/tb_ddr_ctrl.sv

// File: dv/ddr_checker.sv
`timescale 1ns/1ps
`include "ddr_ctrl_defines.svh"

module ddr_checker (
  input logic                       CLK,
  input logic                       RST,
  input logic [`DDR_ADDR_W-1:0]     rand_address,
  input logic                       rand_we,
  input logic                       rand_request,
  input logic                       rand_grant,
  input logic [3:0]                 rand_we_mask,
  input logic [`DDR_ADDR_W-1:0]     bulk_address,
  input logic                       bulk_we,
  input logic                       bulk_request,
  input logic                       bulk_grant,
  input logic [3:0]                 bulk_we_mask,
  input logic [31:0]                wdata,
  input logic [31:0]                rdata,
  input logic                       rdata_valid,
  input ddr_ctrl_pkg::ddr_cmd_e     ddr_cmd,
  input logic [`DDR_PIN_ADDR_W-1:0] ddr_addr,
  input logic [`DDR_BANK_W-1:0]     ddr_bank,
  input logic [15:0]                dq_out,
  input logic                       dq_oe,
  input logic [1:0]                 dm
);

  int err_total = 0;
  int test_err = 0;
  int n_pass = 0;
  int n_fail = 0;
  int cyc = 0;
  int since_ref = 0;
  int refs_seen = 0;
  logic [31:0] shadow [int unsigned];  // word per requester address
  logic [31:0] rd_exp_q [$];
  int          rd_cyc_q [$];
  logic        exp_v [2];
  logic [15:0] exp_d [2];
  logic [1:0]  exp_m [2];
  logic        page_open, reset_checked, prev_rand_req, prev_bulk_req;
  logic [11:0] open_row;
  logic [1:0]  open_bank;
  logic        last_valid, saw_pre, saw_act, saw_ref;
  logic [13:0] last_page;  // row and bank of the previous access

  task automatic flag(input string msg);
    $display("ERROR t=%0t: %s", $time, msg);
    err_total++;
    test_err++;
  endtask

  task automatic note_failure(input string msg);
    $display("%s", msg);
    err_total++;
    test_err++;
  endtask

  task automatic start_test();
    test_err = 0;
  endtask

  task automatic finish_test(input int idx);
    if (test_err == 0)
    begin
      n_pass++;
      $display("test %0d: ok", idx);
    end
    else
    begin
      n_fail++;
      $display("test %0d: %0d error(s)", idx, test_err);
    end
  endtask

  task automatic final_report();
    if (refs_seen == 0)
      note_failure("no AUTO REFRESH was issued during the run");
    if (rd_exp_q.size() != 0)
      note_failure($sformatf("%0d read(s) never returned data", rd_exp_q.size()));
    $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, err_total);
  endtask

  always @(posedge CLK)
  begin
    logic [25:0] a;
    logic        w;
    logic [3:0]  m;
    logic [31:0] word;
    logic [31:0] exp_word;
    int          t0;
    if (!RST)
    begin
      page_open = 1'b0;
      reset_checked = 1'b0;
      prev_rand_req = 1'b0;
      prev_bulk_req = 1'b0;
      exp_v[0] = 1'b0;
      exp_v[1] = 1'b0;
      last_valid = 1'b0;
      since_ref = 0;
    end
    else
    begin
      if (!reset_checked)
      begin
        if (ddr_cmd != ddr_ctrl_pkg::NOP || ddr_addr != `DDR_IDLE_ADDR || rand_grant ||
            bulk_grant || dq_oe || rdata_valid)
          flag("outputs not at reset values after reset");
        reset_checked = 1'b1;
      end
      if (exp_v[0])
      begin
        if (!dq_oe || dq_out !== exp_d[0] || dm !== exp_m[0])
          flag($sformatf("write beat oe=%b dq=%h dm=%b, expected dq=%h dm=%b",
                         dq_oe, dq_out, dm, exp_d[0], exp_m[0]));
      end
      else if (dq_oe)
        flag("dq_oe high with no write beat due");
      exp_v[0] = exp_v[1];
      exp_d[0] = exp_d[1];
      exp_m[0] = exp_m[1];
      exp_v[1] = 1'b0;
      if (rand_grant && prev_bulk_req)
        flag("rand granted while bulk was requesting");
      if ((rand_grant && !prev_rand_req) || (bulk_grant && !prev_bulk_req))
        flag("grant without a pending request");
      case (ddr_cmd)
        ddr_ctrl_pkg::PRE:
        begin
          page_open = 1'b0;
          saw_pre = 1'b1;
        end
        ddr_ctrl_pkg::REF:
        begin
          if (page_open)
            flag("REF issued with a page open");
          refs_seen++;
          since_ref = 0;
          saw_ref = 1'b1;
        end
        ddr_ctrl_pkg::ACT:
        begin
          if (page_open)
            flag("ACT issued with a page already open");
          if (ddr_addr[10])
            flag("ACT carries A10 high");
          open_row = {ddr_addr[12:11], ddr_addr[9:0]};  // row view
          open_bank = ddr_bank;
          page_open = 1'b1;
          saw_act = 1'b1;
        end
        default: ;
      endcase
      if (ddr_cmd == ddr_ctrl_pkg::RD || ddr_cmd == ddr_ctrl_pkg::WR)
      begin
        if (!(rand_grant ^ bulk_grant))
          flag("RD or WR without exactly one grant");
        a = bulk_grant ? bulk_address : rand_address;
        w = bulk_grant ? bulk_we : rand_we;
        m = bulk_grant ? bulk_we_mask : rand_we_mask;
        if ((ddr_cmd == ddr_ctrl_pkg::WR) != w)
          flag($sformatf("command %s does not match we=%b", ddr_cmd.name(), w));
        if (!page_open || open_row != a[25:14] || open_bank != a[13:12])
          flag($sformatf("access to %h outside the open page", a));
        if (ddr_bank != a[13:12] || ddr_addr != {a[11:0], 1'b0})
          flag($sformatf("column word %h bank %0d for address %h", ddr_addr, ddr_bank, a));
        if (last_valid && last_page == a[25:12] && !saw_ref && (saw_pre || saw_act))
          flag("page hit produced PRE or ACT");
        last_valid = 1'b1;
        last_page = a[25:12];
        saw_pre = 1'b0;
        saw_act = 1'b0;
        saw_ref = 1'b0;
        word = shadow.exists(a) ? shadow[a] : 32'h0;
        if (w)
        begin
          for (int i = 0; i < 4; i++)
            if (m[i])
              word[i*8 +: 8] = wdata[i*8 +: 8];
          shadow[a] = word;
          exp_v[0] = 1'b1;
          exp_d[0] = wdata[15:0];
          exp_m[0] = ~m[1:0];
          exp_v[1] = 1'b1;
          exp_d[1] = wdata[31:16];
          exp_m[1] = ~m[3:2];
        end
        else
        begin
          rd_exp_q.push_back(word);
          rd_cyc_q.push_back(cyc);
        end
      end
      if (rdata_valid)
      begin
        if (rd_exp_q.size() == 0)
          flag("rdata_valid with no read outstanding");
        else
        begin
          exp_word = rd_exp_q.pop_front();
          t0 = rd_cyc_q.pop_front();
          if (rdata !== exp_word)
            flag($sformatf("rdata %h, expected %h", rdata, exp_word));
          if (cyc - t0 != `DDR_CAS_LAT + 2)
            flag($sformatf("read data after %0d cycles", cyc - t0));
        end
      end
      since_ref++;
      if (since_ref > `DDR_REFRESH_INTERVAL + 40)
      begin
        flag("no REF within the refresh bound");
        since_ref = 0;
      end
      prev_rand_req = rand_request;
      prev_bulk_req = bulk_request;
      cyc++;
    end
  end

endmodule

// File: dv/ddr_clk_gen.sv
`timescale 1ns/1ps

module ddr_clk_gen (
  output logic CLK,
  output logic RST
);

  initial
  begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;  // 40 ns period
  end

  initial
  begin
    RST = 1'b0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b1;
  end

endmodule

// File: dv/ddr_ctrl_props.sv
`timescale 1ns/1ps
`include "ddr_ctrl_defines.svh"

module ddr_ctrl_props (
  input logic                   CLK,
  input logic                   RST,
  input ddr_ctrl_pkg::ddr_cmd_e ddr_cmd,
  input logic                   rand_grant,
  input logic                   bulk_grant
);

  int since_act, since_pre, since_ref;  // cycles since each command, saturating

  always @(posedge CLK)
  begin
    if (!RST)
    begin
      since_act <= 100;
      since_pre <= 100;
      since_ref <= 100;
    end
    else
    begin
      since_act <= (ddr_cmd == ddr_ctrl_pkg::ACT) ? 1 : (since_act < 100 ? since_act + 1 : 100);
      since_pre <= (ddr_cmd == ddr_ctrl_pkg::PRE) ? 1 : (since_pre < 100 ? since_pre + 1 : 100);
      since_ref <= (ddr_cmd == ddr_ctrl_pkg::REF) ? 1 : (since_ref < 100 ? since_ref + 1 : 100);
    end
  end

  a_nop_after: assert property (@(posedge CLK) disable iff (!RST)
    (ddr_cmd != ddr_ctrl_pkg::NOP) |=> (ddr_cmd == ddr_ctrl_pkg::NOP))
    else $error("command not followed by NOP");

  a_rcd: assert property (@(posedge CLK) disable iff (!RST)
    (ddr_cmd == ddr_ctrl_pkg::RD || ddr_cmd == ddr_ctrl_pkg::WR) |-> since_act >= `DDR_T_RCD)
    else $error("access too soon after ACT");

  a_rp: assert property (@(posedge CLK) disable iff (!RST)
    (ddr_cmd != ddr_ctrl_pkg::NOP) |-> since_pre >= `DDR_T_RP)
    else $error("command too soon after PRE");

  a_rfc: assert property (@(posedge CLK) disable iff (!RST)
    (ddr_cmd != ddr_ctrl_pkg::NOP) |-> since_ref >= `DDR_T_RFC)
    else $error("command too soon after REF");

  a_one_grant: assert property (@(posedge CLK) disable iff (!RST)
    !(rand_grant && bulk_grant))
    else $error("both grants high");

endmodule

bind ddr_cmd_sched ddr_ctrl_props u_props (
  .CLK        (CLK),
  .RST        (RST),
  .ddr_cmd    (ddr_cmd),
  .rand_grant (rand_grant),
  .bulk_grant (bulk_grant)
);

// File: dv/ddr_sdram_model.sv
`timescale 1ns/1ps
`include "ddr_ctrl_defines.svh"

module ddr_sdram_model (
  input  logic                       CLK,
  input  ddr_ctrl_pkg::ddr_cmd_e     ddr_cmd,
  input  logic [`DDR_PIN_ADDR_W-1:0] ddr_addr,
  input  logic [`DDR_BANK_W-1:0]     ddr_bank,
  input  logic [15:0]                dq_out,
  input  logic                       dq_oe,
  input  logic [1:0]                 dm,
  output logic [15:0]                dq_in
);

  logic [7:0]  mem [int unsigned];  // unwritten bytes read as zero
  logic [11:0] open_row [4];
  logic [15:0] beat_q [4];
  logic        beat_v [4];
  logic        wr_active;
  int          wr_beat;
  int unsigned wr_base;
  int unsigned cyc;

  function automatic int unsigned byte_key(input logic [1:0] bank, input logic [11:0] row,
                                           input logic [11:0] col, input int b);
    return {bank, row, col, 2'(b)};
  endfunction

  function automatic logic [7:0] read_byte(input int unsigned key);
    return mem.exists(key) ? mem[key] : 8'h00;
  endfunction

  initial
  begin
    dq_in     = 16'h0;
    wr_active = 1'b0;
    wr_beat   = 0;
    cyc       = 0;
    for (int i = 0; i < 4; i++)
      beat_v[i] = 1'b0;
  end

  always @(posedge CLK)
  begin
    ddr_ctrl_pkg::dram_addr_u word;
    int unsigned base;
    int slot;
    word  = ddr_addr;
    slot  = cyc % 4;
    dq_in <= beat_v[slot] ? beat_q[slot] : 16'h0;
    beat_v[slot] = 1'b0;
    if (wr_active && dq_oe)
    begin
      for (int i = 0; i < 2; i++)
        if (!dm[i])
          mem[wr_base + wr_beat * 2 + i] = dq_out[i*8 +: 8];
      wr_beat++;
      if (wr_beat == 2)
        wr_active = 1'b0;
    end
    case (ddr_cmd)
      ddr_ctrl_pkg::ACT: open_row[ddr_bank] = {word.row.row_hi, word.row.row_lo};
      ddr_ctrl_pkg::RD:
      begin
        base = byte_key(ddr_bank, open_row[ddr_bank], word.col.col, 0);
        beat_q[(cyc + 1) % 4] = {read_byte(base + 1), read_byte(base)};
        beat_v[(cyc + 1) % 4] = 1'b1;
        beat_q[(cyc + 2) % 4] = {read_byte(base + 3), read_byte(base + 2)};
        beat_v[(cyc + 2) % 4] = 1'b1;
      end
      ddr_ctrl_pkg::WR:
      begin
        wr_base   = byte_key(ddr_bank, open_row[ddr_bank], word.col.col, 0);
        wr_active = 1'b1;
        wr_beat   = 0;
      end
      default: ;
    endcase
    cyc++;
  end

endmodule

// File: dv/tb_ddr_ctrl.sv
`timescale 1ns/1ps
`include "ddr_ctrl_defines.svh"

module tb_ddr_ctrl;

  logic CLK, RST;
  logic [25:0] rand_address, bulk_address;
  logic rand_we, rand_request, rand_grant, bulk_we, bulk_request, bulk_grant;
  logic [3:0] rand_we_mask, bulk_we_mask;
  logic [31:0] wdata, rdata;
  logic rdata_valid, dq_oe;
  ddr_ctrl_pkg::ddr_cmd_e ddr_cmd;
  logic [12:0] ddr_addr;
  logic [1:0] ddr_bank, dm;
  logic [15:0] dq_out, dq_in;

  // table: port 0 rand, 1 bulk, 2 both reading; dsel 0 new word, 1 ones, 2 repeat
  int          n_entries = 0;
  logic [1:0]  t_port [32];
  logic        t_we [32];
  logic [25:0] t_addr [32];
  logic [25:0] t_alt [32];  // rand address when both request
  logic [3:0]  t_mask [32];
  logic [1:0]  t_dsel [32];
  int          t_idle [32];
  logic [31:0] lfsr_state = 32'h920e;

  ddr_clk_gen u_clk_gen (.CLK(CLK), .RST(RST));

  ddr_ctrl_top dut (.*);

  ddr_sdram_model u_sdram (.CLK(CLK), .ddr_cmd(ddr_cmd), .ddr_addr(ddr_addr),
    .ddr_bank(ddr_bank), .dq_out(dq_out), .dq_oe(dq_oe), .dm(dm), .dq_in(dq_in));

  ddr_checker chk (.*);

  function automatic logic [25:0] page_addr(input int row, input int bank, input int col);
    return {12'(row), 2'(bank), 12'(col)};
  endfunction

  task automatic add_entry(input int port, input logic we, input logic [25:0] addr,
                           input logic [25:0] alt, input logic [3:0] mask,
                           input int dsel, input int idle);
    t_port[n_entries] = 2'(port);
    t_we[n_entries]   = we;
    t_addr[n_entries] = addr;
    t_alt[n_entries]  = alt;
    t_mask[n_entries] = mask;
    t_dsel[n_entries] = 2'(dsel);
    t_idle[n_entries] = idle;
    n_entries++;
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] next_word();
    logic        fb;
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++)
    begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      w = {w[30:0], fb};
    end
    return w;
  endfunction

  initial
  begin
    logic [31:0] data;
    logic got_bulk, got_rand, need_bulk, need_rand;
    int waited, valids, n_reads;
    rand_address = '0;
    rand_we = 1'b0;
    rand_request = 1'b0;
    rand_we_mask = '0;
    bulk_address = '0;
    bulk_we = 1'b0;
    bulk_request = 1'b0;
    bulk_we_mask = '0;
    wdata = '0;
    data = '0;
    add_entry(1, 1, page_addr(5, 1, 10), 0, 4'hF, 0, 2);
    add_entry(0, 0, page_addr(5, 1, 10), 0, 4'h0, 0, 0);
    add_entry(0, 1, page_addr(5, 1, 10), 0, 4'h3, 0, 0);
    add_entry(0, 1, page_addr(5, 1, 11), 0, 4'h6, 1, 0);  // next column, same page
    add_entry(1, 0, page_addr(5, 1, 10), 0, 4'h0, 0, 0);
    add_entry(0, 0, page_addr(9, 2, 4), 0, 4'h0, 0, 0);  // never written
    add_entry(1, 1, page_addr(9, 2, 5), 0, 4'hA, 0, 1);
    add_entry(0, 0, page_addr(9, 2, 5), 0, 4'h0, 0, 0);
    add_entry(2, 0, page_addr(5, 1, 11), page_addr(9, 2, 5), 4'h0, 0, 0);
    add_entry(0, 1, page_addr(12'hFFF, 3, 12'hFFF), 0, 4'hC, 0, 3);
    add_entry(1, 0, page_addr(12'hFFF, 3, 12'hFFF), 0, 4'h0, 0, 0);
    for (int k = 0; k < 12; k++)  // idle and hit run across refreshes
      add_entry(k % 2, 0, page_addr(12'hFFF, 3, 12'hFFF), 0, 4'h0, 0, 25);
    add_entry(1, 1, page_addr(12'hFFF, 3, 7), 0, 4'h9, 2, 0);
    add_entry(2, 0, page_addr(12'hFFF, 3, 7), page_addr(5, 1, 11), 4'h0, 0, 0);
    waited = 0;
    while (!RST && waited < 100)
    begin
      @(negedge CLK);
      waited++;
    end
    if (!RST)
      chk.note_failure("reset was never released");
    for (int i = 0; i < n_entries; i++)
    begin
      repeat (t_idle[i]) @(negedge CLK);
      if (t_dsel[i] == 0)
        data = next_word();
      else if (t_dsel[i] == 1)
        data = 32'hFFFF_FFFF;
      @(negedge CLK);
      chk.start_test();
      wdata = data;
      need_bulk = (t_port[i] != 0);
      need_rand = (t_port[i] != 1);
      n_reads = t_we[i] ? 0 : ((t_port[i] == 2) ? 2 : 1);
      if (need_bulk)
      begin
        bulk_address = t_addr[i];
        bulk_we = t_we[i];
        bulk_we_mask = t_mask[i];
        bulk_request = 1'b1;
      end
      if (need_rand)
      begin
        rand_address = (t_port[i] == 2) ? t_alt[i] : t_addr[i];
        rand_we = t_we[i];
        rand_we_mask = t_mask[i];
        rand_request = 1'b1;
      end
      got_bulk = 1'b0;
      got_rand = 1'b0;
      valids = 0;
      waited = 0;
      while (((need_bulk && !got_bulk) || (need_rand && !got_rand)) && waited < 100)
      begin
        @(negedge CLK);
        waited++;
        if (rdata_valid)
          valids++;
        if (bulk_grant)
        begin
          if (got_bulk || !need_bulk)
            chk.note_failure($sformatf("test %0d: bulk granted more than once", i));
          got_bulk = 1'b1;
          bulk_request = 1'b0;
        end
        if (rand_grant)
        begin
          if (got_rand || !need_rand)
            chk.note_failure($sformatf("test %0d: rand granted more than once", i));
          got_rand = 1'b1;
          rand_request = 1'b0;
        end
      end
      if ((need_bulk && !got_bulk) || (need_rand && !got_rand))
        chk.note_failure($sformatf("test %0d: no grant within 100 cycles", i));
      bulk_request = 1'b0;
      rand_request = 1'b0;
      waited = 0;
      while (valids < n_reads && waited < 50)
      begin
        @(negedge CLK);
        waited++;
        if (rdata_valid)
          valids++;
      end
      if (valids < n_reads)
        chk.note_failure($sformatf("test %0d: read data never came back", i));
      repeat (4) @(negedge CLK);  // let the last beats and compares settle
      chk.finish_test(i);
    end
    chk.final_report();
    if (chk.err_total == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: hw/ddr_cmd_sched.sv
`timescale 1ns/1ps
`include "ddr_ctrl_defines.svh"

module ddr_cmd_sched (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       refresh_strobe,
  input  logic [`DDR_ADDR_W-1:0]     rand_address,
  input  logic                       rand_we,
  input  logic                       rand_request,
  input  logic [3:0]                 rand_we_mask,
  input  logic [`DDR_ADDR_W-1:0]     bulk_address,
  input  logic                       bulk_we,
  input  logic                       bulk_request,
  input  logic [3:0]                 bulk_we_mask,
  output logic                       rand_grant,
  output logic                       bulk_grant,
  output ddr_ctrl_pkg::ddr_cmd_e     ddr_cmd,
  output logic [`DDR_PIN_ADDR_W-1:0] ddr_addr,
  output logic [`DDR_BANK_W-1:0]     ddr_bank,
  output ddr_ctrl_pkg::ddr_cmd_e     issued_cmd,
  output logic [3:0]                 issued_mask
);

  localparam int T_CCD = 2;  // access to access, one NOP in between
  localparam int T_WR  = 3;  // write to anything other than another write
  localparam int GAP_W = $clog2(`DDR_T_RFC);

  // open page and sequencing state
  logic                    page_open;
  logic [`DDR_ROW_W-1:0]   open_row;
  logic [`DDR_BANK_W-1:0]  open_bank;
  logic                    last_was_write;
  logic                    refresh_ack;
  logic [GAP_W-1:0]        gap_cnt;

  logic                    refresh_pending;
  logic                    any_req;
  logic [`DDR_ADDR_W-1:0]  win_addr;
  logic                    win_we;
  logic [3:0]              win_mask;
  logic [`DDR_ROW_W-1:0]   win_row;
  logic [`DDR_BANK_W-1:0]  win_bank;
  logic [`DDR_COL_W-1:0]   win_col;
  logic                    page_hit;
  logic                    ready;
  logic                    access;
  logic [GAP_W-1:0]        gap_load;

  ddr_ctrl_pkg::ddr_cmd_e     cmd_next;
  ddr_ctrl_pkg::dram_addr_u   addr_word;

  assign refresh_pending = refresh_strobe ^ refresh_ack;

  // bulk always wins when both are asking
  assign any_req  = bulk_request | rand_request;
  assign win_addr = bulk_request ? bulk_address : rand_address;
  assign win_we   = bulk_request ? bulk_we : rand_we;
  assign win_mask = bulk_request ? bulk_we_mask : rand_we_mask;

  assign win_row  = win_addr[`DDR_ADDR_W-1 -: `DDR_ROW_W];
  assign win_bank = win_addr[`DDR_COL_W +: `DDR_BANK_W];
  assign win_col  = win_addr[`DDR_COL_W-1:0];

  // refresh takes precedence over a hit
  assign page_hit = any_req && page_open && !refresh_pending &&
                    (win_row == open_row) && (win_bank == open_bank);

  // a write may chase a write one cycle sooner than other commands
  assign ready = (gap_cnt == '0) ||
                 ((gap_cnt == GAP_W'(1)) && last_was_write && page_hit && win_we);

  always_comb
  begin
    cmd_next = ddr_ctrl_pkg::NOP;
    if (ready)
    begin
      if (page_hit)
        cmd_next = win_we ? ddr_ctrl_pkg::WR : ddr_ctrl_pkg::RD;
      else if (page_open && (any_req || refresh_pending))
        cmd_next = ddr_ctrl_pkg::PRE;  // miss or refresh, close first
      else if (refresh_pending)
        cmd_next = ddr_ctrl_pkg::REF;
      else if (any_req)
        cmd_next = ddr_ctrl_pkg::ACT;
    end
  end

  assign access = (cmd_next == ddr_ctrl_pkg::RD) || (cmd_next == ddr_ctrl_pkg::WR);

  // cycles until the next decision, minus the one spent on the command
  always_comb
  begin
    case (cmd_next)
      ddr_ctrl_pkg::ACT: gap_load = GAP_W'(`DDR_T_RCD - 1);
      ddr_ctrl_pkg::PRE: gap_load = GAP_W'(`DDR_T_RP - 1);
      ddr_ctrl_pkg::REF: gap_load = GAP_W'(`DDR_T_RFC - 1);
      ddr_ctrl_pkg::WR:  gap_load = GAP_W'(T_WR - 1);
      default:           gap_load = GAP_W'(T_CCD - 1);
    endcase
  end

  // the same 13 pins carry a row or a column
  always_comb
  begin
    addr_word = `DDR_IDLE_ADDR;
    if (cmd_next == ddr_ctrl_pkg::ACT)
    begin
      addr_word.row.row_hi   = win_row[`DDR_ROW_W-1:10];
      addr_word.row.auto_pre = 1'b0;
      addr_word.row.row_lo   = win_row[9:0];
    end
    else if (access)
    begin
      addr_word.col.col      = win_col;
      addr_word.col.beat_sel = 1'b0;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      ddr_cmd        <= ddr_ctrl_pkg::NOP;
      ddr_addr       <= `DDR_IDLE_ADDR;
      ddr_bank       <= '0;
      rand_grant     <= 1'b0;
      bulk_grant     <= 1'b0;
      page_open      <= 1'b0;
      last_was_write <= 1'b0;
      refresh_ack    <= 1'b0;
      gap_cnt        <= '0;
    end
    else
    begin
      ddr_cmd    <= cmd_next;
      ddr_addr   <= addr_word;
      rand_grant <= access && !bulk_request;  // grant lines up with RD/WR
      bulk_grant <= access && bulk_request;

      if (cmd_next != ddr_ctrl_pkg::NOP)
      begin
        gap_cnt        <= gap_load;
        last_was_write <= (cmd_next == ddr_ctrl_pkg::WR);
      end
      else if (gap_cnt != '0)
      begin
        gap_cnt <= gap_cnt - 1'b1;
      end

      case (cmd_next)
        ddr_ctrl_pkg::ACT: page_open   <= 1'b1;
        ddr_ctrl_pkg::PRE: page_open   <= 1'b0;
        ddr_ctrl_pkg::REF: refresh_ack <= refresh_strobe;  // clears pending
        default: ;
      endcase

      if ((cmd_next == ddr_ctrl_pkg::ACT) || access)
        ddr_bank <= win_bank;
    end
  end

  // page address and write mask, only meaningful with page_open or a WR
  always_ff @(posedge CLK)
  begin
    if (cmd_next == ddr_ctrl_pkg::ACT)
    begin
      open_row  <= win_row;
      open_bank <= win_bank;
    end
    if (access)
      issued_mask <= win_mask;
  end

  assign issued_cmd = ddr_cmd;

endmodule

// File: hw/ddr_ctrl_pkg.sv
`include "ddr_ctrl_defines.svh"

package ddr_ctrl_pkg;

  // {ras_n, cas_n, we_n} as seen on the pins
  typedef enum logic [2:0] {
    NOP = 3'b111,
    ACT = 3'b011,  // open a row
    RD  = 3'b101,
    WR  = 3'b100,
    BST = 3'b110,  // burst terminate
    PRE = 3'b010,  // close the row
    REF = 3'b001,  // auto refresh
    MRS = 3'b000   // mode register set
  } ddr_cmd_e;

  // pin address as carried by ACT
  typedef struct packed {
    logic [`DDR_ROW_W-11:0] row_hi;    // row bits above A10
    logic                   auto_pre;  // A10, kept low on ACT
    logic [9:0]             row_lo;
  } dram_row_t;

  // pin address as carried by RD and WR
  typedef struct packed {
    logic [`DDR_COL_W-1:0] col;
    logic                  beat_sel;  // first beat always beat 0
  } dram_col_t;

  typedef union packed {
    dram_row_t row;
    dram_col_t col;
  } dram_addr_u;

endpackage

// File: hw/ddr_ctrl_top.sv
`timescale 1ns/1ps
`include "ddr_ctrl_defines.svh"

module ddr_ctrl_top (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic [`DDR_ADDR_W-1:0]     rand_address,
  input  logic                       rand_we,
  input  logic                       rand_request,
  output logic                       rand_grant,
  input  logic [3:0]                 rand_we_mask,
  input  logic [`DDR_ADDR_W-1:0]     bulk_address,
  input  logic                       bulk_we,
  input  logic                       bulk_request,
  output logic                       bulk_grant,
  input  logic [3:0]                 bulk_we_mask,
  input  logic [31:0]                wdata,
  output logic [31:0]                rdata,
  output logic                       rdata_valid,
  output ddr_ctrl_pkg::ddr_cmd_e     ddr_cmd,
  output logic [`DDR_PIN_ADDR_W-1:0] ddr_addr,
  output logic [`DDR_BANK_W-1:0]     ddr_bank,
  output logic [15:0]                dq_out,
  output logic                       dq_oe,
  output logic [1:0]                 dm,
  input  logic [15:0]                dq_in
);

  logic                   refresh_strobe;
  ddr_ctrl_pkg::ddr_cmd_e issued_cmd;
  logic [3:0]             issued_mask;

  ddr_refresh_timer u_refresh_timer (
    .CLK            (CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe)
  );

  ddr_cmd_sched u_cmd_sched (
    .CLK            (CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .rand_address   (rand_address),
    .rand_we        (rand_we),
    .rand_request   (rand_request),
    .rand_we_mask   (rand_we_mask),
    .bulk_address   (bulk_address),
    .bulk_we        (bulk_we),
    .bulk_request   (bulk_request),
    .bulk_we_mask   (bulk_we_mask),
    .rand_grant     (rand_grant),
    .bulk_grant     (bulk_grant),
    .ddr_cmd        (ddr_cmd),
    .ddr_addr       (ddr_addr),
    .ddr_bank       (ddr_bank),
    .issued_cmd     (issued_cmd),
    .issued_mask    (issued_mask)
  );

  ddr_dq_path u_dq_path (
    .CLK         (CLK),
    .RST         (RST),
    .issued_cmd  (issued_cmd),
    .issued_mask (issued_mask),
    .wdata       (wdata),
    .dq_in       (dq_in),
    .dq_out      (dq_out),
    .dq_oe       (dq_oe),
    .dm          (dm),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

endmodule

// File: hw/ddr_dq_path.sv
`timescale 1ns/1ps
`include "ddr_ctrl_defines.svh"

module ddr_dq_path (
  input  logic                   CLK,
  input  logic                   RST,
  input  ddr_ctrl_pkg::ddr_cmd_e issued_cmd,
  input  logic [3:0]             issued_mask,
  input  logic [31:0]            wdata,
  input  logic [15:0]            dq_in,
  output logic [15:0]            dq_out,
  output logic                   dq_oe,
  output logic [1:0]             dm,
  output logic [31:0]            rdata,
  output logic                   rdata_valid
);

  localparam int RD_PIPE_W = `DDR_CAS_LAT + 2;

  logic                 hi_pending;  // beat 1 still to go out
  logic [15:0]          hi_data;
  logic [1:0]           hi_dm;
  logic [RD_PIPE_W-1:0] rd_pipe;     // bit k set k+1 cycles after RD
  logic                 wr_start;

  assign wr_start = (issued_cmd == ddr_ctrl_pkg::WR);

  // write side, beat 0 the cycle after WR and beat 1 right behind it
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      dq_oe      <= 1'b0;
      hi_pending <= 1'b0;
    end
    else
    begin
      dq_oe      <= wr_start | hi_pending;
      hi_pending <= wr_start;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (wr_start)
    begin
      dq_out  <= wdata[15:0];
      dm      <= ~issued_mask[1:0];  // dm high masks the byte
      hi_data <= wdata[31:16];
      hi_dm   <= ~issued_mask[3:2];
    end
    else if (hi_pending)
    begin
      dq_out <= hi_data;
      dm     <= hi_dm;
    end
  end

  // read side
  always_ff @(posedge CLK)
  begin
    if (!RST)
      rd_pipe <= '0;
    else
      rd_pipe <= {rd_pipe[RD_PIPE_W-2:0], issued_cmd == ddr_ctrl_pkg::RD};
  end

  always_ff @(posedge CLK)
  begin
    if (rd_pipe[`DDR_CAS_LAT-1])
      rdata[15:0] <= dq_in;   // beat 0
    if (rd_pipe[`DDR_CAS_LAT])
      rdata[31:16] <= dq_in;  // beat 1
  end

  assign rdata_valid = rd_pipe[RD_PIPE_W-1];

endmodule

// File: hw/ddr_refresh_timer.sv
`timescale 1ns/1ps
`include "ddr_ctrl_defines.svh"

module ddr_refresh_timer (
  input  logic CLK,
  input  logic RST,
  output logic refresh_strobe
);

  localparam int CNT_W = $clog2(`DDR_REFRESH_INTERVAL);

  logic [CNT_W-1:0] count;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      count          <= CNT_W'(`DDR_REFRESH_INTERVAL - 1);
      refresh_strobe <= 1'b0;
    end
    else if (count == '0)
    begin
      count          <= CNT_W'(`DDR_REFRESH_INTERVAL - 1);
      refresh_strobe <= ~refresh_strobe;  // scheduler acks by copying this
    end
    else
    begin
      count <= count - 1'b1;
    end
  end

endmodule

// File: include/ddr_ctrl_defines.svh
`ifndef DDR_CTRL_DEFINES_SVH
`define DDR_CTRL_DEFINES_SVH

// requester address split is row 25:14, bank 13:12, column 11:0
`define DDR_ADDR_W      26
`define DDR_ROW_W       12
`define DDR_COL_W       12
`define DDR_BANK_W      2
`define DDR_PIN_ADDR_W  13

// command spacing in CLK cycles
`define DDR_T_RCD       3   // ACT to RD or WR
`define DDR_T_RP        3   // PRE to next command
`define DDR_T_RFC       8   // REF to next command
`define DDR_CAS_LAT     2   // RD to first beat on dq_in

`define DDR_REFRESH_INTERVAL  200

// A10 high selects all banks on PRE
`define DDR_IDLE_ADDR   13'h0400

`endif
